//--- Makefile
# Verilator build and run of the RV32I multicycle core testbench

OBJ = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing -f all.f --top-module tb_top -Mdir $(OBJ)

run: compile
	./$(OBJ)/Vtb_top | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf $(OBJ) sim.log

//--- all.f
hdl/rv_isa_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/phase_ctrl.sv
hdl/load_store_lanes.sv
hdl/datapath.sv
hdl/rv32i_multicyc.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_top.sv

//--- hdl/alu.sv
// Combinational RV32I ALU.
// The zero flag drives the branch decision in the datapath.
`default_nettype none

module alu import rv_isa_pkg::*; (
	input  alu_op_e op,
	input  word_t   a,
	input  word_t   b,
	output word_t   y,
	output logic    zero
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (op)
			ALU_ADD:  y = a + b;
			ALU_SUB:  y = a - b;
			ALU_SLL:  y = a << shamt;
			ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU: y = {31'b0, a < b};
			ALU_XOR:  y = a ^ b;
			ALU_SRL:  y = a >> shamt;
			ALU_SRA:  y = $signed(a) >>> shamt;
			ALU_OR:   y = a | b;
			ALU_AND:  y = a & b;
			// illegal funct7 combinations fall back to add
			default:  y = a + b;
		endcase
	end

	assign zero = (y == '0);

endmodule

`default_nettype wire

//--- hdl/cpu_ctrl_pkg.sv
// Control-path types: phases, mux selects and the per-cycle control word.
// The phase controller builds the control word, the datapath consumes it.
`default_nettype none

package cpu_ctrl_pkg;
	import rv_isa_pkg::*;

	typedef enum logic [2:0] {
		PH_FETCH,
		PH_DECODE,
		PH_EXECUTE,
		PH_MEM_ACCESS,
		PH_MERGE,
		PH_MEM_WAIT,
		PH_WRITEBACK,
		PH_HALT
	} phase_e;

	typedef enum logic {ADDR_PC, ADDR_ALUOUT} addr_sel_e;
	typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;
	// A_PC is the address of the instruction being executed
	typedef enum logic {A_RS1, A_PC} a_sel_e;
	typedef enum logic {B_RS2, B_IMM} b_sel_e;
	typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_PC, WB_LOAD} wb_sel_e;
	typedef enum logic {WD_RS2, WD_MERGED} wdata_sel_e;

	typedef struct packed {
		logic       pc_write;
		logic       ir_write;
		logic       mdr_write;
		logic       reg_write;
		logic       mem_rd;
		logic       mem_we;
		addr_sel_e  addr_sel;
		pc_sel_e    pc_sel;
		a_sel_e     a_sel;
		b_sel_e     b_sel;
		wb_sel_e    wb_sel;
		wdata_sel_e wdata_sel;
		alu_op_e    alu_op;
	} ctrl_word_t;

	// decoded bits the controller needs back from the instruction register
	typedef struct packed {
		opcode_e    opcode;
		logic [2:0] funct3;
		logic       bit30;
		logic       branch_taken;
	} instr_fields_t;

endpackage

`default_nettype wire

//--- hdl/datapath.sv
// Datapath of the multicycle core: PC, IR, operand and memory registers.
// Every register moves on the clock edge under the control word.
`default_nettype none

module datapath import rv_isa_pkg::*, cpu_ctrl_pkg::*; #(
	parameter word_t reset_addr = RESET_ADDR_DEFAULT
) (
	input  logic          clk,
	input  logic          rst,
	input  ctrl_word_t    ctrl,
	input  word_t         load_data,
	input  word_t         bus_rdata,
	input  word_t         merged_data,
	output instr_fields_t fields,
	output word_t         mem_addr,
	output word_t         store_data,
	output word_t         rs2_data,
	output logic [1:0]    byte_off
);

	word_t   pc;
	word_t   ir;
	word_t   a_reg;
	word_t   b_reg;
	word_t   alu_out;
	word_t   mdr;
	word_t   mar;
	word_t   rf_rd0;
	word_t   rf_rd1;
	word_t   alu_a;
	word_t   alu_b;
	word_t   alu_y;
	word_t   imm;
	word_t   wb_data;
	word_t   next_pc;
	word_t   addr_full;
	logic    alu_zero;
	opcode_e opcode;

	assign opcode = opcode_e'(ir[6:0]);

	reg_file u_reg_file (
		.clk (clk),
		.ra0 (ir[19:15]),
		.ra1 (ir[24:20]),
		.wa  (ir[11:7]),
		.we  (ctrl.reg_write),
		.wd  (wb_data),
		.rd0 (rf_rd0),
		.rd1 (rf_rd1)
	);

	always_comb begin
		case (opcode)
			OPC_LUI, OPC_AUIPC: imm = {ir[31:12], 12'b0};
			OPC_JAL: imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
			OPC_BRANCH: imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
			OPC_STORE: imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			default: imm = {{20{ir[31]}}, ir[31:20]};
		endcase
	end

	// mar keeps the fetch address until a data access replaces it
	assign alu_a = (ctrl.a_sel == A_PC) ? mar : a_reg;
	assign alu_b = (ctrl.b_sel == B_IMM) ? imm : b_reg;

	alu u_alu (
		.op   (ctrl.alu_op),
		.a    (alu_a),
		.b    (alu_b),
		.y    (alu_y),
		.zero (alu_zero)
	);

	always_comb begin
		case (ctrl.pc_sel)
			PC_PLUS4: next_pc = pc + 32'd4;
			PC_JALR:  next_pc = alu_out & ~32'd1;
			default:  next_pc = alu_out;
		endcase
		case (ctrl.wb_sel)
			WB_IMM:  wb_data = imm;
			WB_PC:   wb_data = pc;
			WB_LOAD: wb_data = load_data;
			default: wb_data = alu_out;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= reset_addr;
		else if (ctrl.pc_write)
			pc <= next_pc;
	end

	always_ff @(posedge clk) begin
		a_reg <= rf_rd0;
		b_reg <= rf_rd1;
		alu_out <= alu_y;
		if (ctrl.ir_write)
			ir <= bus_rdata;
		// read data during the access, merged word otherwise
		if (ctrl.mdr_write)
			mdr <= ctrl.mem_rd ? bus_rdata : merged_data;
		if (ctrl.mem_rd || ctrl.mem_we)
			mar <= addr_full;
	end

	assign addr_full = (ctrl.addr_sel == ADDR_ALUOUT) ? alu_out : pc;
	assign mem_addr = {addr_full[31:2], 2'b00};
	assign byte_off = mar[1:0];
	assign store_data = (ctrl.wdata_sel == WD_RS2) ? b_reg : mdr;
	assign rs2_data = b_reg;

	// taken when the compare result matches the condition, see funct3 bits 0 and 2
	always_comb begin
		fields.opcode = opcode;
		fields.funct3 = ir[14:12];
		fields.bit30 = ir[30];
		fields.branch_taken = alu_zero ^ ir[12] ^ ir[14];
	end

	a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hdl/load_store_lanes.sv
// Byte lanes between the datapath and the byte-reversed memory bus.
// Extracts and extends load data, merges SB/SH data into the read word.
`default_nettype none

module load_store_lanes import rv_isa_pkg::*; (
	input  word_t      rdata_bus,
	input  word_t      mdr,
	input  word_t      rs2_data,
	input  logic [1:0] byte_off,
	input  logic [2:0] funct3,
	output word_t      rdata_le,
	output word_t      load_data,
	output word_t      merged_data,
	output word_t      wdata_bus,
	input  word_t      store_word
);

	mem_width_e width;
	logic [7:0]  load_byte;
	logic [15:0] load_half;
	logic        unsigned_ld;

	// lowest address sits in bus bits 31..24
	function automatic word_t swap_bytes(input word_t w);
		swap_bytes = {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	assign rdata_le = swap_bytes(rdata_bus);
	assign wdata_bus = swap_bytes(store_word);

	assign width = mem_width_e'(funct3[1:0]);
	assign unsigned_ld = funct3[2];
	assign load_byte = mdr[8 * byte_off +: 8];
	assign load_half = byte_off[1] ? mdr[31:16] : mdr[15:0];

	always_comb begin
		case (width)
			MEM_BYTE: load_data = {{24{load_byte[7] & ~unsigned_ld}}, load_byte};
			MEM_HALF: load_data = {{16{load_half[15] & ~unsigned_ld}}, load_half};
			default:  load_data = mdr;
		endcase
	end

	// other lanes keep what the read returned
	always_comb begin
		merged_data = mdr;
		if (width == MEM_HALF)
			merged_data[16 * byte_off[1] +: 16] = rs2_data[15:0];
		else
			merged_data[8 * byte_off +: 8] = rs2_data[7:0];
	end

endmodule

`default_nettype wire

//--- hdl/phase_ctrl.sv
// Phase FSM of the multicycle core, with opcode decode.
// Produces one control word per cycle and stalls on the bus ready.
`default_nettype none

module phase_ctrl import rv_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  instr_fields_t fields,
	input  logic          ready,
	output ctrl_word_t    ctrl,
	output logic          halted
);

	phase_e  phase;
	phase_e  phase_n;
	a_sel_e  exec_a;
	b_sel_e  exec_b;
	alu_op_e exec_op;
	alu_op_e cmp_op;
	logic    sub_word;
	logic    is_mem;

	// SB and SH have funct3[1] clear, SW has it set
	assign sub_word = ~fields.funct3[1];
	assign is_mem = (fields.opcode == OPC_LOAD) || (fields.opcode == OPC_STORE);
	// signed or unsigned less-than for BLT/BGE/BLTU/BGEU, equality via subtract
	assign cmp_op = fields.funct3[2] ? alu_op_e'({3'b001, fields.funct3[1]}) : ALU_SUB;

	// ALU setup from EXECUTE on, held so that ALUOut stays valid as bus address
	always_comb begin
		exec_a = A_RS1;
		exec_b = B_IMM;
		exec_op = ALU_ADD;
		case (fields.opcode)
			OPC_OP: begin
				exec_b = B_RS2;
				exec_op = alu_op_e'({fields.bit30, fields.funct3});
			end
			OPC_OP_IMM: begin
				// only SRAI carries bit 30 into the operation
				exec_op = alu_op_e'({fields.bit30 && fields.funct3 == 3'b101, fields.funct3});
			end
			// branch target or AUIPC sum
			OPC_AUIPC, OPC_BRANCH: exec_a = A_PC;
			default: ;
		endcase
	end

	always_comb begin
		ctrl.pc_write = 1'b0;
		ctrl.ir_write = 1'b0;
		ctrl.mdr_write = 1'b0;
		ctrl.reg_write = 1'b0;
		ctrl.mem_rd = 1'b0;
		ctrl.mem_we = 1'b0;
		ctrl.addr_sel = ADDR_PC;
		ctrl.pc_sel = PC_PLUS4;
		ctrl.a_sel = exec_a;
		ctrl.b_sel = exec_b;
		ctrl.wb_sel = WB_ALU;
		ctrl.wdata_sel = WD_MERGED;
		ctrl.alu_op = exec_op;
		case (phase)
			PH_FETCH: begin
				ctrl.mem_rd = 1'b1;
				ctrl.ir_write = ready;
			end
			PH_DECODE: begin
				ctrl.pc_write = 1'b1;
				// jal target from the fetch address
				ctrl.a_sel = A_PC;
				ctrl.b_sel = B_IMM;
				ctrl.alu_op = ALU_ADD;
			end
			PH_MEM_ACCESS: begin
				ctrl.addr_sel = ADDR_ALUOUT;
				if (fields.opcode == OPC_STORE && !sub_word) begin
					ctrl.mem_we = 1'b1;
					ctrl.wdata_sel = WD_RS2;
				end else begin
					// loads, and the read half of SB/SH
					ctrl.mem_rd = 1'b1;
					ctrl.mdr_write = ready;
				end
			end
			PH_MERGE: begin
				ctrl.addr_sel = ADDR_ALUOUT;
				ctrl.mdr_write = 1'b1;
			end
			PH_MEM_WAIT: begin
				ctrl.addr_sel = ADDR_ALUOUT;
				ctrl.mem_we = 1'b1;
			end
			PH_WRITEBACK: begin
				case (fields.opcode)
					OPC_LUI: begin
						ctrl.reg_write = 1'b1;
						ctrl.wb_sel = WB_IMM;
					end
					OPC_JAL, OPC_JALR: begin
						ctrl.reg_write = 1'b1;
						ctrl.wb_sel = WB_PC;
						ctrl.pc_write = 1'b1;
						ctrl.pc_sel = (fields.opcode == OPC_JAL) ? PC_JAL : PC_JALR;
					end
					OPC_BRANCH: begin
						// compare now, ALUOut still holds the target
						ctrl.a_sel = A_RS1;
						ctrl.b_sel = B_RS2;
						ctrl.alu_op = cmp_op;
						ctrl.pc_write = fields.branch_taken;
						ctrl.pc_sel = PC_BRANCH;
					end
					OPC_LOAD: begin
						ctrl.reg_write = 1'b1;
						ctrl.wb_sel = WB_LOAD;
					end
					default: ctrl.reg_write = 1'b1;
				endcase
			end
			default: ;
		endcase
	end

	always_comb begin
		phase_n = phase;
		case (phase)
			PH_FETCH: if (ready) phase_n = PH_DECODE;
			PH_DECODE: begin
				case (fields.opcode)
					OPC_LUI, OPC_JAL: phase_n = PH_WRITEBACK;
					// fence has nothing to order in this core
					OPC_MISC_MEM: phase_n = PH_FETCH;
					OPC_AUIPC, OPC_JALR, OPC_BRANCH, OPC_LOAD,
					OPC_STORE, OPC_OP_IMM, OPC_OP: phase_n = PH_EXECUTE;
					default: phase_n = PH_HALT;
				endcase
			end
			PH_EXECUTE: phase_n = is_mem ? PH_MEM_ACCESS : PH_WRITEBACK;
			PH_MEM_ACCESS: begin
				if (ready) begin
					if (fields.opcode == OPC_LOAD)
						phase_n = PH_WRITEBACK;
					else if (sub_word)
						phase_n = PH_MERGE;
					else
						phase_n = PH_FETCH;
				end
			end
			PH_MERGE: phase_n = PH_MEM_WAIT;
			// merged write completes the store, next comes a fetch
			PH_MEM_WAIT: if (ready) phase_n = PH_FETCH;
			PH_WRITEBACK: phase_n = PH_FETCH;
			default: phase_n = PH_HALT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			phase <= PH_FETCH;
		else
			phase <= phase_n;
	end

	assign halted = (phase == PH_HALT);

	a_one_strobe: assert property (@(posedge clk) disable iff (rst)
		!(ctrl.mem_rd && ctrl.mem_we));

	// a bus access without ready keeps the core in its phase
	a_stall_holds: assert property (@(posedge clk) disable iff (rst)
		(ctrl.mem_rd || ctrl.mem_we) && !ready |=> $stable(phase));

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
// 32 x 32 integer register file, two read ports and one write port.
// x0 reads as zero and ignores writes.
`default_nettype none

module reg_file import rv_isa_pkg::*; (
	input  logic      clk,
	input  reg_addr_t ra0,
	input  reg_addr_t ra1,
	input  reg_addr_t wa,
	input  logic      we,
	input  word_t     wd,
	output word_t     rd0,
	output word_t     rd1
);

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (we && wa != '0)
			regs[wa] <= wd;
	end

	// entry 0 is never written, so mask it on read
	assign rd0 = (ra0 == '0) ? '0 : regs[ra0];
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];

endmodule

`default_nettype wire

//--- hdl/rv32i_multicyc.sv
// Multicycle RV32I core with one byte-reversed 32-bit memory bus.
// Requests hold until ready; halted rises on an unsupported opcode.
`default_nettype none

module rv32i_multicyc import rv_isa_pkg::*, cpu_ctrl_pkg::*; #(
	parameter word_t reset_addr = RESET_ADDR_DEFAULT
) (
	input  logic  clk,
	input  logic  rst,
	output word_t addr,
	output word_t wdata,
	output logic  rd,
	output logic  we,
	output logic  halted,
	input  word_t rdata,
	input  logic  ready
);

	ctrl_word_t    ctrl;
	instr_fields_t fields;
	word_t         rdata_le;
	word_t         load_data;
	word_t         merged_data;
	word_t         store_data;
	word_t         rs2_data;
	logic [1:0]    byte_off;

	phase_ctrl u_phase_ctrl (
		.clk    (clk),
		.rst    (rst),
		.fields (fields),
		.ready  (ready),
		.ctrl   (ctrl),
		.halted (halted)
	);

	datapath #(
		.reset_addr (reset_addr)
	) u_datapath (
		.clk         (clk),
		.rst         (rst),
		.ctrl        (ctrl),
		.load_data   (load_data),
		.bus_rdata   (rdata_le),
		.merged_data (merged_data),
		.fields      (fields),
		.mem_addr    (addr),
		.store_data  (store_data),
		.rs2_data    (rs2_data),
		.byte_off    (byte_off)
	);

	// store_data carries the MDR except while SW drives rs2
	load_store_lanes u_lanes (
		.rdata_bus   (rdata),
		.mdr         (store_data),
		.rs2_data    (rs2_data),
		.byte_off    (byte_off),
		.funct3      (fields.funct3),
		.rdata_le    (rdata_le),
		.load_data   (load_data),
		.merged_data (merged_data),
		.wdata_bus   (wdata),
		.store_word  (store_data)
	);

	assign rd = ctrl.mem_rd;
	assign we = ctrl.mem_we;

endmodule

`default_nettype wire

//--- hdl/rv_isa_pkg.sv
// RV32I instruction-set encodings shared by the core.
// Import where opcodes, ALU operations or the data word type are needed.
`default_nettype none

package rv_isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// fetch address after reset unless the top level overrides it
	localparam word_t RESET_ADDR_DEFAULT = 32'hf000_0000;

	// major opcodes handled by the core, anything else halts
	typedef enum logic [6:0] {
		OPC_LUI      = 7'b0110111,
		OPC_AUIPC    = 7'b0010111,
		OPC_JAL      = 7'b1101111,
		OPC_JALR     = 7'b1100111,
		OPC_BRANCH   = 7'b1100011,
		OPC_LOAD     = 7'b0000011,
		OPC_STORE    = 7'b0100011,
		OPC_OP_IMM   = 7'b0010011,
		OPC_OP       = 7'b0110011,
		OPC_MISC_MEM = 7'b0001111
	} opcode_e;

	// {instr[30], funct3}
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SUB  = 4'b1000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_SRA  = 4'b1101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111
	} alu_op_e;

	// funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		MEM_BYTE = 2'b00,
		MEM_HALF = 2'b01,
		MEM_WORD = 2'b10
	} mem_width_e;

endpackage

`default_nettype wire

//--- verification/tb_checker.sv
// Reference model of the program image, checks bus writes and the halt.
// Predicts every completed write in bus byte order before the core starts.
`default_nettype none

module tb_checker import rv_isa_pkg::*; #(
	parameter word_t base = RESET_ADDR_DEFAULT
) (
	input  logic  clk,
	input  logic  rst,
	input  word_t addr,
	input  word_t wdata,
	input  logic  rd,
	input  logic  we,
	input  logic  ready,
	input  logic  halted,
	input  word_t image [1024],
	input  logic  load_done,
	output logic  predicted,
	output logic  halt_seen,
	output int    mismatches,
	output int    failures,
	output int    instr_count,
	output int    writes_seen,
	output int    writes_expected
);

	word_t ref_mem [1024];
	word_t xr [32];
	word_t exp_addr [$];
	word_t exp_data [$];

	function automatic word_t byte_swap(input word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic int word_index(input word_t a);
		word_t o;
		o = a - base;
		return int'(o[11:2]);
	endfunction

	function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
			input word_t a, input word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return word_t'($signed(a) >>> b[4:0]);
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// executes ref_mem from base, returns instructions run including the halt
	function automatic int predict();
		word_t ins;
		word_t pc;
		word_t next;
		word_t r;
		word_t rs1;
		word_t rs2;
		word_t ea;
		word_t le;
		word_t imm_i;
		word_t imm_s;
		word_t imm_b;
		logic [2:0] f3;
		logic [4:0] rd_idx;
		logic wr;
		int idx;
		int n;
		int k;
		pc = base;
		for (k = 0; k < 32; k++)
			xr[k] = '0;
		for (n = 0; n < 4000; n++) begin
			ins = byte_swap(ref_mem[word_index(pc)]);
			f3 = ins[14:12];
			rd_idx = ins[11:7];
			rs1 = xr[ins[19:15]];
			rs2 = xr[ins[24:20]];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			next = pc + 4;
			wr = 1'b1;
			r = '0;
			case (ins[6:0])
				7'h37: r = {ins[31:12], 12'b0};
				7'h17: r = pc + {ins[31:12], 12'b0};
				7'h6f: begin
					r = pc + 4;
					next = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
				end
				7'h67: begin
					r = pc + 4;
					next = (rs1 + imm_i) & ~32'd1;
				end
				7'h63: begin
					wr = 1'b0;
					if (branch_ref(f3, rs1, rs2))
						next = pc + imm_b;
				end
				7'h03: begin
					ea = rs1 + imm_i;
					le = byte_swap(ref_mem[word_index(ea)]) >> (8 * ea[1:0]);
					case (f3)
						3'd0: r = {{24{le[7]}}, le[7:0]};
						3'd4: r = {24'b0, le[7:0]};
						3'd1: r = {{16{le[15]}}, le[15:0]};
						3'd5: r = {16'b0, le[15:0]};
						default: r = le;
					endcase
				end
				7'h23: begin
					wr = 1'b0;
					ea = rs1 + imm_s;
					idx = word_index(ea);
					le = byte_swap(ref_mem[idx]);
					case (f3)
						3'd0: le[8 * ea[1:0] +: 8] = rs2[7:0];
						3'd1: le[8 * ea[1:0] +: 16] = rs2[15:0];
						default: le = rs2;
					endcase
					ref_mem[idx] = byte_swap(le);
					exp_addr.push_back({ea[31:2], 2'b00});
					exp_data.push_back(ref_mem[idx]);
				end
				7'h13: r = alu_ref(f3, f3 == 3'd5 && ins[30], rs1, imm_i);
				7'h33: r = alu_ref(f3, ins[30], rs1, rs2);
				7'h0f: wr = 1'b0;
				default: return n + 1;
			endcase
			if (wr && rd_idx != 0)
				xr[rd_idx] = r;
			pc = next;
		end
		return n;
	endfunction

	initial begin
		predicted = 1'b0;
		wait (load_done);
		ref_mem = image;
		instr_count = predict();
		writes_expected = exp_addr.size();
		predicted = 1'b1;
	end

	always @(posedge clk) begin
		if (rst) begin
			mismatches = 0;
			failures = 0;
			writes_seen = 0;
			halt_seen = 1'b0;
		end else if (predicted) begin
			if (we && ready) begin
				if (writes_seen >= writes_expected) begin
					failures++;
					$display("write to %h beyond the predicted writes", addr);
				end else begin
					if (addr !== exp_addr[writes_seen]) begin
						mismatches++;
						$display("MISMATCH time=%0t signal=addr expected=%h actual=%h",
							$time, exp_addr[writes_seen], addr);
					end
					if (wdata !== exp_data[writes_seen]) begin
						mismatches++;
						$display("MISMATCH time=%0t signal=wdata expected=%h actual=%h",
							$time, exp_data[writes_seen], wdata);
					end
					writes_seen++;
				end
			end
			if (halted) begin
				if (!halt_seen && writes_seen != writes_expected) begin
					failures++;
					$display("halted after %0d of %0d writes", writes_seen, writes_expected);
				end
				halt_seen = 1'b1;
				if (rd || we) begin
					failures++;
					$display("bus request at %0t while halted", $time);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
// Testbench clock with a 10-unit period and a reset held for two cycles.
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		rst = 1'b1;
		repeat (2) @(negedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

//--- verification/tb_top.sv
// Testbench top: program memory with random ready latency, DUT and checker.
// Runs until the core halts and the bus stays quiet, or until the cycle limit.
`default_nettype none

module tb_top import rv_isa_pkg::*; ();

	localparam word_t BASE = RESET_ADDR_DEFAULT;
	localparam int SETTLE_CYCLES = 20;

	logic  clk;
	logic  rst;
	word_t addr;
	word_t wdata;
	word_t rdata = '0;
	logic  rd;
	logic  we;
	logic  ready = 1'b0;
	logic  halted;
	word_t mem [1024];
	word_t lcg_state = 32'hd977_ecc9;
	word_t rnd;
	logic  busy = 1'b0;
	int    wait_left = 0;
	int    prog_idx;
	int    res_off;
	logic  load_done = 1'b0;
	logic  predicted;
	logic  halt_seen;
	logic  timed_out;
	int    mismatches;
	int    failures;
	int    instr_count;
	int    writes_seen;
	int    writes_expected;
	int    cycles;
	int    limit;
	int    settle;

	tb_clock u_clock (
		.clk (clk),
		.rst (rst)
	);

	rv32i_multicyc #(
		.reset_addr (BASE)
	) uut (
		.clk    (clk),
		.rst    (rst),
		.addr   (addr),
		.wdata  (wdata),
		.rd     (rd),
		.we     (we),
		.halted (halted),
		.rdata  (rdata),
		.ready  (ready)
	);

	tb_checker #(
		.base (BASE)
	) u_checker (
		.clk             (clk),
		.rst             (rst),
		.addr            (addr),
		.wdata           (wdata),
		.rd              (rd),
		.we              (we),
		.ready           (ready),
		.halted          (halted),
		.image           (mem),
		.load_done       (load_done),
		.predicted       (predicted),
		.halt_seen       (halt_seen),
		.mismatches      (mismatches),
		.failures        (failures),
		.instr_count     (instr_count),
		.writes_seen     (writes_seen),
		.writes_expected (writes_expected)
	);

	function automatic word_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic word_t byte_swap(input word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic int word_index(input word_t a);
		word_t o;
		o = a - BASE;
		return int'(o[11:2]);
	endfunction

	function automatic word_t r_type(input int f7, input int rs2, input int rs1,
			input int f3, input int rd_i);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd_i[4:0], 7'h33};
	endfunction

	function automatic word_t i_type(input int imm, input int rs1, input int f3,
			input int rd_i, input int op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd_i[4:0], op[6:0]};
	endfunction

	function automatic word_t s_type(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
	endfunction

	function automatic word_t b_type(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic word_t u_type(input int imm, input int rd_i, input int op);
		return {imm[19:0], rd_i[4:0], op[6:0]};
	endfunction

	function automatic word_t j_type(input int imm, input int rd_i);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd_i[4:0], 7'h6f};
	endfunction

	// memory holds instructions in bus byte order
	task automatic emit(input word_t ins);
		mem[prog_idx] = byte_swap(ins);
		prog_idx++;
	endtask

	// results go to consecutive words at x2
	task automatic store_result(input int rs);
		emit(s_type(res_off, rs, 2, 2));
		res_off += 4;
	endtask

	task automatic build_program();
		for (int i = 0; i < 1024; i++)
			mem[i] = (i < 512) ? '0 : lcg_next() ^ (BASE + 4 * i);
		prog_idx = 0;
		res_off = 0;
		// x1 data area, x2 result area, x3/x4 random operands
		emit(u_type('hf0000, 1, 'h37));
		emit(i_type(2047, 1, 0, 1, 'h13));
		emit(i_type(1, 1, 0, 1, 'h13));
		emit(i_type(1024, 1, 0, 2, 'h13));
		emit(i_type(0, 1, 2, 3, 'h03));
		emit(i_type(4, 1, 2, 4, 'h03));
		for (int f = 0; f < 8; f++) begin
			emit(r_type(0, 4, 3, f, 6));
			store_result(6);
		end
		emit(r_type('h20, 4, 3, 0, 6));
		store_result(6);
		emit(r_type('h20, 4, 3, 5, 6));
		store_result(6);
		for (int f = 0; f < 8; f++) begin
			rnd = lcg_next();
			if (f == 1 || f == 5)
				emit(i_type(int'(rnd[4:0]), 3, f, 6, 'h13));
			else
				emit(i_type(int'(rnd[11:0]), 3, f, 6, 'h13));
			store_result(6);
		end
		emit(i_type(int'({7'h20, rnd[4:0]}), 3, 5, 6, 'h13));
		store_result(6);
		rnd = lcg_next();
		emit(u_type(int'(rnd[19:0]), 6, 'h37));
		store_result(6);
		emit(u_type(int'(rnd[31:12]), 6, 'h17));
		store_result(6);
		// x7 ends as 1 when the branch skips the second addi
		for (int f = 0; f < 8; f++) begin
			for (int p = 0; p < 3; p++) begin
				if (f != 2 && f != 3) begin
					emit(i_type(1, 0, 0, 7, 'h13));
					emit(b_type(8, (p == 0) ? 4 : 3, (p == 1) ? 4 : 3, f));
					emit(i_type(2, 0, 0, 7, 'h13));
					store_result(7);
				end
			end
		end
		emit(j_type(8, 8));
		emit(i_type(0, 0, 0, 8, 'h13));
		store_result(8);
		// odd offset checks that jalr clears bit 0
		emit(u_type(0, 9, 'h17));
		emit(i_type(13, 9, 0, 10, 'h67));
		emit(i_type(0, 0, 0, 10, 'h13));
		store_result(10);
		for (int o = 0; o < 4; o++) begin
			emit(i_type(12 + o, 1, 0, 6, 'h03));
			store_result(6);
			emit(i_type(12 + o, 1, 4, 6, 'h03));
			store_result(6);
			if (o % 2 == 0) begin
				emit(i_type(12 + o, 1, 1, 6, 'h03));
				store_result(6);
				emit(i_type(12 + o, 1, 5, 6, 'h03));
				store_result(6);
			end
		end
		emit(i_type(12, 1, 2, 6, 'h03));
		store_result(6);
		for (int o = 0; o < 4; o++)
			emit(s_type(64 + o, 3, 1, 0));
		emit(s_type(80, 4, 1, 1));
		emit(s_type(82, 4, 1, 1));
		emit(32'h0000_000f);
		store_result(3);
		// ecall is not supported and halts the core
		emit(32'h0000_0073);
	endtask

	// each request waits 0 to 3 cycles before ready
	always @(negedge clk) begin
		if (ready) begin
			ready = 1'b0;
			busy = 1'b0;
		end else if (rd || we) begin
			if (!busy) begin
				busy = 1'b1;
				wait_left = int'(lcg_next() >> 30);
			end
			if (wait_left == 0) begin
				ready = 1'b1;
				if (we)
					mem[word_index(addr)] = wdata;
				else
					rdata = mem[word_index(addr)];
			end else begin
				wait_left--;
			end
		end
	end

	initial begin
		timed_out = 1'b0;
		build_program();
		load_done = 1'b1;
		wait (predicted);
		limit = instr_count * 12 + 100;
		cycles = 0;
		settle = 0;
		while (settle < SETTLE_CYCLES && !timed_out) begin
			@(posedge clk);
			cycles++;
			if (halt_seen)
				settle++;
			if (cycles >= limit)
				timed_out = 1'b1;
		end
		if (timed_out)
			$display("timeout after %0d cycles, halt not reached, %0d of %0d writes seen",
				cycles, writes_seen, writes_expected);
		$display("errors: %0d mismatches, %0d other failures",
			mismatches, failures + int'(timed_out));
		if (mismatches == 0 && failures == 0 && !timed_out)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
